//--- compile.f
+incdir+sim
design/wdb_pkg.sv
design/half_line_ram.sv
design/write_intake.sv
design/read_merge.sv
design/write_data_buffer.sv
sim/wdb_tb.sv

//--- design/half_line_ram.sv
////////////////////////////////////////////////////////////
// tag indexed half line store, one write and one read port
// read data appears one clock after the read address
// a read and a write to the same entry in one cycle see old data
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module half_line_ram #(
  parameter int DEPTH = wdb_pkg::LINE_DEPTH
) (
  input  logic                         clock,
  input  logic                         we,
  input  logic [wdb_pkg::TAG_BITS-1:0] wr_addr,
  input  wdb_pkg::half_line_t          data_in,
  input  logic [wdb_pkg::TAG_BITS-1:0] rd_addr,
  output wdb_pkg::half_line_t          data_out
);

  import wdb_pkg::*;

  // block ram style array, no reset on the contents
  half_line_t mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  // whole half line per write, no byte enables
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // registered read, address is sampled every cycle
  always_ff @(posedge clock) begin
    data_out <= mem[rd_addr];
  end

  // a smaller tag space must never be written past its end
  wr_addr_in_range: assert property (
    @(posedge clock) we |-> (32'(wr_addr) < DEPTH)
  ) else begin
    $error("half_line_ram write to %0d beyond depth %0d", wr_addr, DEPTH);
  end

endmodule

//--- design/read_merge.sv
////////////////////////////////////////////////////////////
// host read pipeline over the two half line rams
// fixed READ_LATENCY, one request per cycle, no back-pressure
// a high half read frees its line and returns one credit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_merge (
  input  logic                         clock,
  input  logic                         rstn,
  input  logic                         enabled,
  input  logic                         rd_valid,
  input  wdb_pkg::rd_req_t             rd_req,
  output logic [wdb_pkg::TAG_BITS-1:0] rd_tag,
  input  wdb_pkg::half_line_t          lo_out,
  input  wdb_pkg::half_line_t          hi_out,
  output logic                         rsp_valid,
  output wdb_pkg::rd_rsp_t             rsp,
  output logic                         credit_release
);

  import wdb_pkg::*;

  // stage 1, request register in front of the ram address
  logic    s1_valid;
  rd_req_t s1_req;
  // stage 2, lines up with the ram read data
  logic    s2_valid;
  rd_req_t s2_req;

  // stage 2 merge result
  half_line_t          sel_data;
  logic [DW_COUNT-1:0] sel_par;
  logic                sel_tag_err;

  ////////////////////////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= rd_valid && enabled;
    end
  end

  // tag parity travels with the request
  always_ff @(posedge clock) begin
    if (rd_valid && enabled) begin
      s1_req <= rd_req;
    end
  end

  // both rams read the same entry
  assign rd_tag = s1_req.tag;

  ////////////////////////////////////////////////////////////
  // stage 2
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (s1_valid) begin
      s2_req <= s1_req;
    end
  end

  // half select, fresh data parity, tag parity recheck
  always_comb begin
    sel_data    = s2_req.half ? hi_out : lo_out;
    sel_par     = odd_parity_dw(sel_data);
    sel_tag_err = (odd_parity_tag(s2_req.tag) != s2_req.tag_par);
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////

  // credit goes back together with the high half response
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rsp_valid      <= 1'b0;
      credit_release <= 1'b0;
    end else begin
      rsp_valid      <= s2_valid;
      credit_release <= s2_valid && s2_req.half;
    end
  end

  // response payload holds between reads
  always_ff @(posedge clock) begin
    if (s2_valid) begin
      rsp.data     <= sel_data;
      rsp.data_par <= sel_par;
      rsp.tag_err  <= sel_tag_err;
    end
  end

  // every enabled request is answered after exactly READ_LATENCY
  rsp_follows_req: assert property (
    @(posedge clock) disable iff (!rstn)
    (rd_valid && enabled) |-> ##READ_LATENCY rsp_valid
  ) else begin
    $error("read_merge response missing %0d cycles after request", READ_LATENCY);
  end

  // and no response shows up without one
  rsp_has_req: assert property (
    @(posedge clock) disable iff (!rstn)
    rsp_valid |-> $past(rd_valid && enabled, READ_LATENCY)
  ) else begin
    $error("read_merge response without a matching request");
  end

endmodule

//--- design/wdb_pkg.sv
////////////////////////////////////////////////////////////
// sizes, bus types and parity helpers of the write buffer
// half lines are little endian, double word i is bits 64i+63:64i
// all parity here is odd, ones including the parity bit are odd
////////////////////////////////////////////////////////////

package wdb_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // tag space, one ram entry per tag
  localparam int TAG_BITS       = 8;
  localparam int LINE_DEPTH     = 1 << TAG_BITS;
  // a 128 byte line is staged as two 64 byte halves
  localparam int HALF_LINE_BITS = 512;
  localparam int DW_COUNT       = 8;
  localparam int DW_BITS        = HALF_LINE_BITS / DW_COUNT;
  // lines the accelerator may hold before the host frees one
  localparam int CREDIT_COUNT   = 16;
  // counter must reach CREDIT_COUNT itself
  localparam int CNT_BITS       = $clog2(CREDIT_COUNT + 1);
  // request register, ram read, output register
  localparam int READ_LATENCY   = 3;

  ////////////////////////////////////////////////////////////
  // bus types
  ////////////////////////////////////////////////////////////

  typedef logic [HALF_LINE_BITS-1:0] half_line_t;

  // accelerator write command, both halves in one beat
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    half_line_t          data_lo;
    half_line_t          data_hi;
  } wr_cmd_t;

  // host read request
  // half 0 selects the low half, 1 the high half
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic                tag_par;
    logic                half;
  } rd_req_t;

  // read response, data_par bit i covers double word i
  typedef struct packed {
    half_line_t          data;
    logic [DW_COUNT-1:0] data_par;
    logic                tag_err;
  } rd_rsp_t;

  ////////////////////////////////////////////////////////////
  // parity
  ////////////////////////////////////////////////////////////

  function automatic logic [DW_COUNT-1:0] odd_parity_dw(input half_line_t data);
    logic [DW_COUNT-1:0] par;
    for (int i = 0; i < DW_COUNT; i++) begin
      par[i] = ~^data[i*DW_BITS +: DW_BITS];
    end
    return par;
  endfunction

  function automatic logic odd_parity_tag(input logic [TAG_BITS-1:0] tag);
    return ~^tag;
  endfunction

endpackage

//--- design/write_data_buffer.sv
////////////////////////////////////////////////////////////
// write data staging buffer of the coherent bus port
// enabled_in takes effect one cycle late, inputs are ignored while low
// a tag may be read from the third cycle after its write command
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module write_data_buffer (
  input  logic             clock,
  input  logic             rstn,
  input  logic             enabled_in,
  input  logic             cmd_valid,
  input  wdb_pkg::wr_cmd_t cmd,
  output logic             credit_return,
  output logic             cmd_overrun,
  input  logic             rd_valid,
  input  wdb_pkg::rd_req_t rd_req,
  output logic             rsp_valid,
  output wdb_pkg::rd_rsp_t rsp
);

  import wdb_pkg::*;

  logic                enabled;
  // shared write port of both rams
  logic                ram_we;
  logic [TAG_BITS-1:0] ram_tag;
  half_line_t          lo_data;
  half_line_t          hi_data;
  // shared read port of both rams
  logic [TAG_BITS-1:0] rd_tag;
  half_line_t          lo_out;
  half_line_t          hi_out;
  // freed line, back to intake and out as a credit
  logic                credit_release;

  ////////////////////////////////////////////////////////////
  // enable
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  write_intake i_write_intake (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .credit_release (credit_release),
    .ram_we         (ram_we),
    .ram_tag        (ram_tag),
    .lo_data        (lo_data),
    .hi_data        (hi_data),
    .cmd_overrun    (cmd_overrun)
  );

  // low half of every line
  half_line_ram #(.DEPTH(LINE_DEPTH)) i_ram_lo (
    .clock    (clock),
    .we       (ram_we),
    .wr_addr  (ram_tag),
    .data_in  (lo_data),
    .rd_addr  (rd_tag),
    .data_out (lo_out)
  );

  // high half, written in the same cycle
  half_line_ram #(.DEPTH(LINE_DEPTH)) i_ram_hi (
    .clock    (clock),
    .we       (ram_we),
    .wr_addr  (ram_tag),
    .data_in  (hi_data),
    .rd_addr  (rd_tag),
    .data_out (hi_out)
  );

  read_merge i_read_merge (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .rd_valid       (rd_valid),
    .rd_req         (rd_req),
    .rd_tag         (rd_tag),
    .lo_out         (lo_out),
    .hi_out         (hi_out),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .credit_release (credit_release)
  );

  assign credit_return = credit_release;

endmodule

//--- design/write_intake.sv
////////////////////////////////////////////////////////////
// accepts write commands while the accelerator holds credits
// one cycle from command to the shared ram write port
// a command with all lines outstanding is dropped, overrun pulses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module write_intake (
  input  logic                         clock,
  input  logic                         rstn,
  input  logic                         enabled,
  input  logic                         cmd_valid,
  input  wdb_pkg::wr_cmd_t             cmd,
  input  logic                         credit_release,
  output logic                         ram_we,
  output logic [wdb_pkg::TAG_BITS-1:0] ram_tag,
  output wdb_pkg::half_line_t          lo_data,
  output wdb_pkg::half_line_t          hi_data,
  output logic                         cmd_overrun
);

  import wdb_pkg::*;

  // lines written and not yet freed by a high half read
  logic [CNT_BITS-1:0] outstanding;
  logic                lines_full;
  logic                cmd_seen;
  logic                cmd_accept;

  // commands only count while the buffer is enabled
  assign cmd_seen   = cmd_valid && enabled;
  assign lines_full = (outstanding == CNT_BITS'(CREDIT_COUNT));
  // a release in the same cycle does not reopen a full buffer
  assign cmd_accept = cmd_seen && !lines_full;

  ////////////////////////////////////////////////////////////
  // write port registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ram_we      <= 1'b0;
      cmd_overrun <= 1'b0;
    end else begin
      ram_we      <= cmd_accept;
      cmd_overrun <= cmd_seen && lines_full;
    end
  end

  // rejected data never reaches the rams
  always_ff @(posedge clock) begin
    if (cmd_accept) begin
      ram_tag <= cmd.tag;
      lo_data <= cmd.data_lo;
      hi_data <= cmd.data_hi;
    end
  end

  ////////////////////////////////////////////////////////////
  // outstanding line count
  ////////////////////////////////////////////////////////////

  // accept and release together leave the count as it is
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      outstanding <= '0;
    end else begin
      case ({cmd_accept, credit_release})
        2'b10:   outstanding <= outstanding + CNT_BITS'(1);
        2'b01:   outstanding <= outstanding - CNT_BITS'(1);
        default: outstanding <= outstanding;
      endcase
    end
  end

  count_within_credits: assert property (
    @(posedge clock) disable iff (!rstn) outstanding <= CNT_BITS'(CREDIT_COUNT)
  ) else begin
    $error("write_intake holds %0d lines, more than the credits", outstanding);
  end

  // host freed a line that was never staged
  release_has_line: assert property (
    @(posedge clock) disable iff (!rstn) credit_release |-> (outstanding != '0)
  ) else begin
    $error("write_intake credit release with no line outstanding");
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module wdb_tb -Mdir obj_dir -o wdb_sim -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/wdb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- sim/wdb_model.svh
////////////////////////////////////////////////////////////
// reference model of the write buffer, included in wdb_tb
// lines are stored when the command is sent, reads keep the gap
// parity is recounted bit by bit from the odd parity rule
////////////////////////////////////////////////////////////

`ifndef WDB_MODEL_SVH
`define WDB_MODEL_SVH

// staged lines by tag
half_line_t model_lo [LINE_DEPTH];
half_line_t model_hi [LINE_DEPTH];
// accelerator side credits, expected pulse counts
int credits;
int exp_credit_pulses;
int exp_overruns;
// expected responses and the edge each one is sampled at
rd_rsp_t want_q [$];
int      due_q [$];

// odd parity per double word, set when the double word has an even count of ones
function automatic logic [DW_COUNT-1:0] dw_odd_bits(input half_line_t data);
  logic [DW_COUNT-1:0] bits;
  int ones;
  for (int i = 0; i < DW_COUNT; i++) begin
    ones = 0;
    for (int b = 0; b < HALF_LINE_BITS / DW_COUNT; b++) begin
      if (data[i * (HALF_LINE_BITS / DW_COUNT) + b]) ones++;
    end
    bits[i] = (ones % 2 == 0);
  end
  return bits;
endfunction

function automatic logic tag_odd_bit(input logic [TAG_BITS-1:0] tag);
  int ones;
  ones = 0;
  for (int b = 0; b < TAG_BITS; b++) begin
    if (tag[b]) ones++;
  end
  return (ones % 2 == 0);
endfunction

// spends a credit, with none left the command is an overrun
function automatic bit store_line(input logic [TAG_BITS-1:0] tag,
                                  input half_line_t lo, input half_line_t hi);
  if (credits == 0) begin
    exp_overruns++;
    return 1'b0;
  end
  credits--;
  model_lo[tag] = lo;
  model_hi[tag] = hi;
  return 1'b1;
endfunction

// high half reads free a line, so one credit pulse each
function automatic void expect_read(input rd_req_t req, input int due);
  rd_rsp_t want;
  want.data     = req.half ? model_hi[req.tag] : model_lo[req.tag];
  want.data_par = dw_odd_bits(want.data);
  want.tag_err  = (req.tag_par != tag_odd_bit(req.tag));
  want_q.push_back(want);
  due_q.push_back(due);
  if (req.half) exp_credit_pulses++;
endfunction

`endif

//--- sim/wdb_tb.sv
////////////////////////////////////////////////////////////
// random write and read traffic against the write buffer
// six tests in sequence, reads keep a gap after their writes
// outputs sampled on the rising edge, before the dut updates
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wdb_tb;

  import wdb_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 8;
  localparam logic [31:0] SEED         = 32'ha3a0_ddc5;
  // per test cycle budgets plus margin
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 + 60 + 60 + 100 + 100 + 100 + 200;

  logic    clock;
  logic    rstn;
  logic    enabled_in;
  logic    cmd_valid;
  wr_cmd_t cmd;
  logic    credit_return;
  logic    cmd_overrun;
  logic    rd_valid;
  rd_req_t rd_req;
  logic    rsp_valid;
  rd_rsp_t rsp;

  int                  cyc;
  int                  errors;
  int                  mark;
  int                  tests_ok;
  int                  tests_bad;
  int                  credit_pulses;
  int                  overrun_pulses;
  bit                  dut_on;
  int                  order [16];
  int                  swap_j;
  int                  swap_v;
  logic [TAG_BITS-1:0] keep_tag;
  logic [TAG_BITS-1:0] tags [16];

  `include "wdb_model.svh"

  write_data_buffer i_dut (
    .clock         (clock),
    .rstn          (rstn),
    .enabled_in    (enabled_in),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .credit_return (credit_return),
    .cmd_overrun   (cmd_overrun),
    .rd_valid      (rd_valid),
    .rd_req        (rd_req),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog stopped the run after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t want);
    if (got.data !== want.data) begin
      $display("Fail at %0t: rsp.data got %h expected %h", $time, got.data, want.data);
      errors++;
    end
    if (got.data_par !== want.data_par) begin
      $display("Fail at %0t: rsp.data_par got %b expected %b", $time, got.data_par,
               want.data_par);
      errors++;
    end
    if (got.tag_err !== want.tag_err) begin
      $display("Fail at %0t: rsp.tag_err got %b expected %b", $time, got.tag_err,
               want.tag_err);
      errors++;
    end
  endtask

  task automatic check_credit(input string what, input int got, input int want);
    if (got != want) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_overrun(input int got, input int want);
    if (got != want) begin
      $display("Fail at %0t: cmd_overrun pulses got %0d expected %0d", $time, got, want);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (rstn) begin
      if (rsp_valid) begin
        if (want_q.size() == 0) begin
          $display("Error at %0t: response with no read outstanding", $time);
          errors++;
        end else begin
          if (due_q[0] != cyc) begin
            $display("Fail at %0t: rsp_valid cycle got %0d expected %0d", $time, cyc,
                     due_q[0]);
            errors++;
          end
          check_rsp(rsp, want_q[0]);
          void'(want_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        $display("Error at %0t: read response due at cycle %0d never came", $time, due_q[0]);
        errors++;
        void'(want_q.pop_front());
        void'(due_q.pop_front());
      end
      if (credit_return) begin
        credit_pulses++;
        credits++;
        if (credits > CREDIT_COUNT) begin
          $display("Error at %0t: more credits returned than spent", $time);
          errors++;
        end
      end
      if (cmd_overrun) overrun_pulses++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic half_line_t rand_half();
    half_line_t h;
    for (int i = 0; i < HALF_LINE_BITS / 32; i++) begin
      h[i*32 +: 32] = $urandom;
    end
    return h;
  endfunction

  // distinct random tags, avoid of -1 excludes nothing
  task automatic pick_tags(input int n, input int avoid);
    logic [TAG_BITS-1:0] t;
    bit                  dup;
    for (int i = 0; i < n; i++) begin
      do begin
        t   = TAG_BITS'($urandom);
        dup = (int'(t) == avoid);
        for (int j = 0; j < i; j++) begin
          if (tags[j] == t) dup = 1'b1;
        end
      end while (dup);
      tags[i] = t;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      cmd_valid <= 1'b0;
      rd_valid  <= 1'b0;
    end
  endtask

  task automatic send_cmd(input logic [TAG_BITS-1:0] tag);
    half_line_t lo;
    half_line_t hi;
    lo = rand_half();
    hi = rand_half();
    @(posedge clock);
    cmd_valid <= 1'b1;
    rd_valid  <= 1'b0;
    cmd       <= '{tag: tag, data_lo: lo, data_hi: hi};
    if (dut_on) void'(store_line(tag, lo, hi));
  endtask

  // par_ok low sends the inverted tag parity
  task automatic send_read(input logic [TAG_BITS-1:0] tag, input logic half, input bit par_ok);
    rd_req_t req;
    req.tag     = tag;
    req.half    = half;
    req.tag_par = tag_odd_bit(tag) ^ !par_ok;
    @(posedge clock);
    rd_valid  <= 1'b1;
    cmd_valid <= 1'b0;
    rd_req    <= req;
    if (dut_on) expect_read(req, cyc + READ_LATENCY + 1);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while (want_q.size() != 0 && waited < READ_LATENCY + 2) begin
      idle(1);
      waited++;
    end
    idle(2);
  endtask

  // enable register in the dut adds one cycle
  task automatic set_enable(input logic v);
    @(posedge clock);
    enabled_in <= v;
    cmd_valid  <= 1'b0;
    rd_valid   <= 1'b0;
    idle(2);
    dut_on = v;
  endtask

  task automatic end_test(input string name);
    if (errors == mark) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", name, errors - mark);
      tests_bad++;
    end
    mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rstn       <= 1'b0;
    enabled_in <= 1'b0;
    cmd_valid  <= 1'b0;
    cmd        <= '0;
    rd_valid   <= 1'b0;
    rd_req     <= '0;
    errors            = 0;
    mark              = 0;
    tests_ok          = 0;
    tests_bad         = 0;
    credit_pulses     = 0;
    overrun_pulses    = 0;
    credits           = CREDIT_COUNT;
    exp_credit_pulses = 0;
    exp_overruns      = 0;
    dut_on            = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    rstn <= 1'b1;
    set_enable(1'b1);

    // one read at a time, low then high
    pick_tags(8, -1);
    for (int i = 0; i < 8; i++) send_cmd(tags[i]);
    idle(3);
    for (int i = 0; i < 8; i++) begin
      send_read(tags[i], 1'b0, 1'b1);
      drain();
      send_read(tags[i], 1'b1, 1'b1);
      drain();
    end
    keep_tag = tags[0];
    end_test("write_then_read");

    // shuffled halves on consecutive cycles
    pick_tags(8, int'(keep_tag));
    for (int i = 0; i < 8; i++) send_cmd(tags[i]);
    idle(3);
    for (int k = 0; k < 16; k++) order[k] = k;
    for (int k = 15; k > 0; k--) begin
      swap_j        = int'($urandom_range(k, 0));
      swap_v        = order[k];
      order[k]      = order[swap_j];
      order[swap_j] = swap_v;
    end
    for (int k = 0; k < 16; k++) send_read(tags[order[k] % 8], 1'(order[k] / 8), 1'b1);
    drain();
    end_test("back_to_back_reads");

    // wrong and right tag parity mixed
    pick_tags(4, int'(keep_tag));
    for (int i = 0; i < 4; i++) send_cmd(tags[i]);
    idle(3);
    for (int i = 0; i < 4; i++) begin
      send_read(tags[i], 1'b0, 1'b0);
      send_read(tags[i], 1'b0, 1'b1);
      send_read(tags[i], 1'b1, 1'(i % 2));
    end
    drain();
    end_test("tag_parity");

    // all credits out, only high halves bring them back
    pick_tags(16, int'(keep_tag));
    for (int i = 0; i < 16; i++) send_cmd(tags[i]);
    idle(3);
    check_credit("credits held", credits, 0);
    for (int i = 0; i < 16; i++) send_read(tags[i], 1'b0, 1'b1);
    drain();
    check_credit("credit pulses", credit_pulses, exp_credit_pulses);
    for (int i = 0; i < 16; i++) send_read(tags[i], 1'b1, 1'b1);
    drain();
    check_credit("credit pulses", credit_pulses, exp_credit_pulses);
    check_credit("credits held", credits, CREDIT_COUNT);
    end_test("credits");

    // seventeenth command to keep_tag must be dropped
    pick_tags(16, int'(keep_tag));
    for (int i = 0; i < 16; i++) send_cmd(tags[i]);
    send_cmd(keep_tag);
    idle(3);
    check_overrun(overrun_pulses, exp_overruns);
    send_read(keep_tag, 1'b0, 1'b1);
    send_read(keep_tag, 1'b1, 1'b1);
    for (int i = 0; i < 15; i++) send_read(tags[i], 1'b1, 1'b1);
    drain();
    check_credit("credit pulses", credit_pulses, exp_credit_pulses);
    end_test("overrun");

    // buffer has room, a command let through would overwrite keep_tag
    set_enable(1'b0);
    send_cmd(keep_tag);
    send_read(keep_tag, 1'b1, 1'b1);
    idle(6);
    set_enable(1'b1);
    // every line staged, a command let through now would overrun
    for (int i = 0; i < 16; i++) send_cmd(tags[i]);
    idle(3);
    set_enable(1'b0);
    send_cmd(keep_tag);
    send_read(tags[15], 1'b1, 1'b1);
    idle(6);
    check_credit("credit pulses", credit_pulses, exp_credit_pulses);
    check_overrun(overrun_pulses, exp_overruns);
    set_enable(1'b1);
    send_read(keep_tag, 1'b0, 1'b1);
    send_read(keep_tag, 1'b1, 1'b1);
    for (int i = 0; i < 15; i++) send_read(tags[i], 1'b1, 1'b1);
    drain();
    check_credit("credit pulses", credit_pulses, exp_credit_pulses);
    check_credit("credits held", credits, CREDIT_COUNT);
    end_test("enable");

    $display("tests ok %0d, tests failing %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
